//--- bench/link_input.txt
# columns: source, input word, expected output (all hex)
# source 0 expects the word itself, source 1 the region id of the low 16 address bits
0 01234567 01234567
0 89abcdef 89abcdef
0 deadbeef deadbeef
0 00000000 00000000
0 ffffffff ffffffff
0 a5a5a5a5 a5a5a5a5
1 00000000 00000000
1 abcd0fff 00000000
1 00001000 00000001
1 7fff3fff 00000001
1 00004000 00000002
1 00017fff 00000002
1 00008000 00000003
1 ffffffff 00000003
0 5a5a5a5a 5a5a5a5a
1 12341001 00000001
0 00000001 00000001
1 ffff4001 00000002
0 80000000 80000000
1 00009abc 00000003
0 13579bdf 13579bdf
1 00000ffe 00000000
0 cafef00d cafef00d
1 5555c000 00000003
0 0f1e2d3c 0f1e2d3c
1 00005a5a 00000002

//--- sim.f
rtl/link_cfg_pkg.sv
rtl/mem_layout_pkg.sv
rtl/beat_transmit.sv
rtl/bus_arbiter.sv
rtl/beat_receive.sv
rtl/serial_link_top.sv
bench/link_assert.sv
bench/link_tb.sv

//--- run.sh
#!/bin/sh
# compile the link testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module link_tb -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vlink_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation run ended with status $status"
	exit $status
fi
exit 0

//--- bench/link_tb.sv
`default_nettype none
`timescale 1ns/10ps

module link_tb;
	import link_cfg_pkg::*;
	import mem_layout_pkg::*;

	localparam int BUS_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int CLK_PERIOD = 40;
	localparam int WORD_CYCLES = 40;
	localparam int RAW_ALONE = 6;
	localparam int ADDR_ALONE = 8;

	logic clk = 1'b0;
	logic rst_n;
	logic in_req0;
	logic in_req1;
	logic in_ack0;
	logic in_ack1;
	logic [DATA_WIDTH-1:0] in_data0;
	logic [DATA_WIDTH-1:0] in_data1;
	logic out_req;
	logic out_ack;
	logic [DATA_WIDTH-1:0] out_data;
	src_t out_src;

	// stimulus and expected results, file order within each source
	logic [DATA_WIDTH-1:0] raw_words[$];
	logic [DATA_WIDTH-1:0] addr_words[$];
	logic [DATA_WIDTH-1:0] raw_q[$];
	region_t region_q[$];
	int n_records = 0;
	int got_raw = 0;
	int got_addr = 0;
	logic loaded = 1'b0;
	logic run_ended = 1'b0;
	logic src_fixed = 1'b1;
	src_t phase_src;
	string test_name;
	logic [31:0] rng_state;

	serial_link_top #(.BUS_WIDTH(BUS_WIDTH), .DATA_WIDTH(DATA_WIDTH)) dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_req0(in_req0),
		.in_ack0(in_ack0),
		.in_data0(in_data0),
		.in_req1(in_req1),
		.in_ack1(in_ack1),
		.in_data1(in_data1),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_data(out_data),
		.out_src(out_src)
	);

	bind serial_link_top link_assert #(.DATA_WIDTH(DATA_WIDTH)) handshake_checks (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_with_failure(input string why);
		run_ended = 1'b1;
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error %s: data expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_src(input string name, input src_t expected, input src_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error %s: source expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_region(input string name, input region_t expected,
		input region_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error %s: region expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic ack_of(input src_t src);
		return (src == SRC_RAW) ? in_ack0 : in_ack1;
	endfunction

	task automatic load_records();
		int fd;
		int n;
		string line;
		logic [31:0] src_v;
		logic [DATA_WIDTH-1:0] word_v;
		logic [DATA_WIDTH-1:0] exp_v;
		fd = $fopen("bench/link_input.txt", "r");
		if (fd == 0) begin
			stop_with_failure("cannot open bench/link_input.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// skip comment and blank lines
			if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h", src_v, word_v, exp_v);
				if (n != 3 || src_v > 1) begin
					stop_with_failure({"bad record in bench/link_input.txt: ", line});
				end
				if (src_v == 0) begin
					raw_words.push_back(word_v);
					raw_q.push_back(exp_v);
				end else begin
					addr_words.push_back(word_v);
					region_q.push_back(region_t'(exp_v));
				end
				n_records++;
			end
		end
		$fclose(fd);
	endtask

	// four-phase client: req up, wait ack, req down, wait ack low
	task automatic send_words(input src_t src, input int first, input int count);
		logic [DATA_WIDTH-1:0] word;
		for (int i = first; i < first + count; i++) begin
			word = (src == SRC_RAW) ? raw_words[i] : addr_words[i];
			@(posedge clk);
			if (src == SRC_RAW) begin
				in_data0 <= word;
				in_req0 <= 1'b1;
			end else begin
				in_data1 <= word;
				in_req1 <= 1'b1;
			end
			do @(posedge clk); while (ack_of(src) !== 1'b1);
			if (src == SRC_RAW) begin
				in_req0 <= 1'b0;
			end else begin
				in_req1 <= 1'b0;
			end
			do @(posedge clk); while (ack_of(src) !== 1'b0);
		end
	endtask

	task automatic wait_for_results(input int n_raw, input int n_addr);
		while (got_raw < n_raw || got_addr < n_addr) begin
			@(posedge clk);
		end
	endtask

	initial begin : main_sequence
		rst_n = 1'b0;
		in_req0 = 1'b0;
		in_req1 = 1'b0;
		in_data0 = '0;
		in_data1 = '0;
		out_ack = 1'b0;
		rng_state = 32'hc4f0;
		load_records();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "raw_alone";
		phase_src = SRC_RAW;
		send_words(SRC_RAW, 0, RAW_ALONE);
		wait_for_results(RAW_ALONE, 0);

		test_name = "addr_alone";
		phase_src = SRC_ADDR;
		send_words(SRC_ADDR, 0, ADDR_ALONE);
		wait_for_results(RAW_ALONE, ADDR_ALONE);

		// arbitration order between the two is not fixed here
		test_name = "both_busy";
		src_fixed = 1'b0;
		fork
			send_words(SRC_RAW, RAW_ALONE, raw_words.size() - RAW_ALONE);
			send_words(SRC_ADDR, ADDR_ALONE, addr_words.size() - ADDR_ALONE);
		join
		wait_for_results(raw_words.size(), addr_words.size());

		// a duplicate would still show up in this window
		repeat (50) @(posedge clk);
		run_ended = 1'b1;
		$display("Simulation passed");
		$finish;
	end

	initial begin : collect_results
		logic [DATA_WIDTH-1:0] exp_word;
		region_t exp_region;
		int delay;
		wait (rst_n === 1'b1);
		forever begin
			do @(posedge clk); while (out_req !== 1'b1);
			if (src_fixed) begin
				check_src(test_name, phase_src, out_src);
			end
			if (out_src == SRC_RAW) begin
				if (raw_q.size() == 0) begin
					stop_with_failure("a source 0 word arrived that was never sent");
				end
				exp_word = raw_q.pop_front();
				check_data(test_name, exp_word, out_data);
				got_raw++;
			end else begin
				if (region_q.size() == 0) begin
					stop_with_failure("a source 1 result arrived that was never sent");
				end
				exp_region = region_q.pop_front();
				check_region(test_name, exp_region, out_data[1:0]);
				check_data(test_name, DATA_WIDTH'(exp_region), out_data);
				got_addr++;
			end
			// random back-pressure, 0 to 20 cycles
			rng_state = xorshift32(rng_state);
			delay = int'(rng_state % 21);
			repeat (delay) @(posedge clk);
			out_ack <= 1'b1;
			do @(posedge clk); while (out_req === 1'b1);
			out_ack <= 1'b0;
		end
	end

	initial begin : watchdog
		wait (loaded === 1'b1);
		#(n_records * WORD_CYCLES * CLK_PERIOD);
		stop_with_failure("timeout: not every expected result arrived in time");
	end

	final begin
		if (!run_ended) begin
			$display("Simulation failed");
		end
	end

endmodule

`default_nettype wire

//--- bench/link_assert.sv
`default_nettype none
`timescale 1ns/10ps

module link_assert #(
	parameter int DATA_WIDTH = link_cfg_pkg::DEF_DATA_WIDTH
) (
	input wire clk,
	input wire rst_n,
	input wire in_req0,
	input wire in_ack0,
	input wire in_req1,
	input wire in_ack1,
	input wire out_req,
	input wire [DATA_WIDTH-1:0] out_data,
	input wire bus_valid,
	input wire bus_ready,
	input wire bus_last,
	input wire link_cfg_pkg::src_t bus_src
);

	// ack held until the client drops req
	ack_hold0: assert property (@(posedge clk) disable iff (!rst_n)
		in_req0 && in_ack0 |=> in_ack0)
		else $error("in_ack0 fell while in_req0 was still high");

	ack_hold1: assert property (@(posedge clk) disable iff (!rst_n)
		in_req1 && in_ack1 |=> in_ack1)
		else $error("in_ack1 fell while in_req1 was still high");

	out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_req |=> !out_req || $stable(out_data))
		else $error("out_data changed while out_req was high");

	// owner fixed until the last beat is taken
	src_locked: assert property (@(posedge clk) disable iff (!rst_n)
		bus_valid && !(bus_ready && bus_last) |=> $stable(bus_src))
		else $error("bus_src changed in the middle of a word");

endmodule

`default_nettype wire

//--- rtl/serial_link_top.sv
`default_nettype none
`timescale 1ns/10ps

module serial_link_top #(
	parameter int BUS_WIDTH = link_cfg_pkg::DEF_BUS_WIDTH,
	parameter int DATA_WIDTH = link_cfg_pkg::DEF_DATA_WIDTH
) (
	input wire clk,
	input wire rst_n,
	input wire in_req0,
	output logic in_ack0,
	input wire [DATA_WIDTH-1:0] in_data0,
	input wire in_req1,
	output logic in_ack1,
	input wire [DATA_WIDTH-1:0] in_data1,
	output logic out_req,
	input wire out_ack,
	output logic [DATA_WIDTH-1:0] out_data,
	output link_cfg_pkg::src_t out_src
);
	import link_cfg_pkg::*;

	logic [N_SRC-1:0] tx_want;
	logic [N_SRC-1:0] grant;
	logic [N_SRC-1:0] tx_valid;
	logic [N_SRC-1:0] tx_last;
	logic [N_SRC-1:0] tx_ready;
	logic [BUS_WIDTH-1:0] tx_data0;
	logic [BUS_WIDTH-1:0] tx_data1;

	logic bus_valid;
	logic [BUS_WIDTH-1:0] bus_data;
	logic bus_last;
	src_t bus_src;
	logic bus_ready;

	// raw words
	beat_transmit #(.BUS_WIDTH(BUS_WIDTH), .DATA_WIDTH(DATA_WIDTH)) tx_raw (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req0),
		.in_ack(in_ack0),
		.in_data(in_data0),
		.tx_want(tx_want[SRC_RAW]),
		.grant(grant[SRC_RAW]),
		.tx_valid(tx_valid[SRC_RAW]),
		.tx_data(tx_data0),
		.tx_last(tx_last[SRC_RAW]),
		.tx_ready(tx_ready[SRC_RAW])
	);

	// memory addresses
	beat_transmit #(.BUS_WIDTH(BUS_WIDTH), .DATA_WIDTH(DATA_WIDTH)) tx_addr (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req1),
		.in_ack(in_ack1),
		.in_data(in_data1),
		.tx_want(tx_want[SRC_ADDR]),
		.grant(grant[SRC_ADDR]),
		.tx_valid(tx_valid[SRC_ADDR]),
		.tx_data(tx_data1),
		.tx_last(tx_last[SRC_ADDR]),
		.tx_ready(tx_ready[SRC_ADDR])
	);

	bus_arbiter #(.BUS_WIDTH(BUS_WIDTH)) arb (
		.clk(clk),
		.rst_n(rst_n),
		.tx_want(tx_want),
		.grant(grant),
		.tx_valid(tx_valid),
		.tx_data0(tx_data0),
		.tx_data1(tx_data1),
		.tx_last(tx_last),
		.tx_ready(tx_ready),
		.bus_valid(bus_valid),
		.bus_data(bus_data),
		.bus_last(bus_last),
		.bus_src(bus_src),
		.bus_ready(bus_ready)
	);

	beat_receive #(.BUS_WIDTH(BUS_WIDTH), .DATA_WIDTH(DATA_WIDTH)) rx (
		.clk(clk),
		.rst_n(rst_n),
		.bus_valid(bus_valid),
		.bus_data(bus_data),
		.bus_last(bus_last),
		.bus_src(bus_src),
		.bus_ready(bus_ready),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_data(out_data),
		.out_src(out_src)
	);

endmodule

`default_nettype wire

//--- rtl/beat_receive.sv
`default_nettype none
`timescale 1ns/10ps

module beat_receive #(
	parameter int BUS_WIDTH = link_cfg_pkg::DEF_BUS_WIDTH,
	parameter int DATA_WIDTH = link_cfg_pkg::DEF_DATA_WIDTH
) (
	input wire clk,
	input wire rst_n,
	input wire bus_valid,
	input wire [BUS_WIDTH-1:0] bus_data,
	input wire bus_last,
	input wire link_cfg_pkg::src_t bus_src,
	output logic bus_ready,
	output logic out_req,
	input wire out_ack,
	output logic [DATA_WIDTH-1:0] out_data,
	output link_cfg_pkg::src_t out_src
);
	import link_cfg_pkg::*;
	import mem_layout_pkg::*;

	localparam int BEATS = DATA_WIDTH / BUS_WIDTH;
	localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS - 1);

	typedef enum logic [1:0] {
		collect,
		present,
		wait_drop
	} rx_state_t;

	rx_state_t state;
	beat_cnt_t beat_cnt;
	logic [DATA_WIDTH-1:0] word;
	logic [DATA_WIDTH-1:0] full_word;
	logic [DATA_WIDTH-1:0] result;
	logic beat_in;
	logic word_end;

	// bus held off while a result waits on the output port
	assign bus_ready = (state == collect);
	assign beat_in = bus_valid && bus_ready;

	// bus_last ends the word, the counter also stops a runaway word
	assign word_end = beat_in && (bus_last || beat_cnt == LAST_BEAT);

	// newest beat enters at the top, first beat ends up lowest
	assign full_word = (word >> BUS_WIDTH)
		| (DATA_WIDTH'(bus_data) << (DATA_WIDTH - BUS_WIDTH));

	always_comb begin
		if (bus_src == SRC_ADDR) begin
			result = DATA_WIDTH'(addr_to_region(addr_t'(full_word[15:0])));
		end else begin
			result = full_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= collect;
			out_req <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				collect: begin
					if (word_end) begin
						beat_cnt <= '0;
						out_req <= 1'b1;
						state <= present;
					end else if (beat_in) begin
						beat_cnt <= beat_cnt + 1'b1;
					end
				end
				present: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state <= wait_drop;
					end
				end
				wait_drop: begin
					if (!out_ack) begin
						state <= collect;
					end
				end
				default: state <= collect;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (beat_in) begin
			word <= full_word;
		end
		if (word_end) begin
			out_data <= result;
			out_src <= bus_src;
		end
	end

endmodule

`default_nettype wire

//--- rtl/bus_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module bus_arbiter #(
	parameter int BUS_WIDTH = link_cfg_pkg::DEF_BUS_WIDTH
) (
	input wire clk,
	input wire rst_n,
	input wire [link_cfg_pkg::N_SRC-1:0] tx_want,
	output logic [link_cfg_pkg::N_SRC-1:0] grant,
	input wire [link_cfg_pkg::N_SRC-1:0] tx_valid,
	input wire [BUS_WIDTH-1:0] tx_data0,
	input wire [BUS_WIDTH-1:0] tx_data1,
	input wire [link_cfg_pkg::N_SRC-1:0] tx_last,
	output logic [link_cfg_pkg::N_SRC-1:0] tx_ready,
	output logic bus_valid,
	output logic [BUS_WIDTH-1:0] bus_data,
	output logic bus_last,
	output link_cfg_pkg::src_t bus_src,
	input wire bus_ready
);
	import link_cfg_pkg::*;

	logic locked;
	src_t owner;
	logic word_done;
	logic free;
	logic [N_SRC-1:0] want_eff;
	logic [N_SRC-1:0] next_grant;
	src_t pick;

	// owner is the current or most recent grant
	assign bus_src = owner;
	assign bus_valid = grant[owner] && tx_valid[owner];
	assign bus_last = grant[owner] && tx_last[owner];
	assign bus_data = (owner == SRC_ADDR) ? tx_data1 : tx_data0;
	assign tx_ready = grant & {N_SRC{bus_ready}};

	assign word_done = bus_valid && bus_ready && bus_last;
	assign free = !locked || word_done;

	always_comb begin
		// finishing owner still shows a stale want this cycle
		want_eff = word_done ? (tx_want & ~grant) : tx_want;
		if (&want_eff) begin
			pick = src_t'(~owner);
		end else if (want_eff[SRC_ADDR]) begin
			pick = SRC_ADDR;
		end else begin
			pick = SRC_RAW;
		end
		next_grant = '0;
		if (|want_eff) begin
			next_grant[pick] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant <= '0;
			locked <= 1'b0;
			owner <= SRC_ADDR;
		end else if (free) begin
			grant <= next_grant;
			locked <= |want_eff;
			if (|want_eff) begin
				owner <= pick;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/beat_transmit.sv
`default_nettype none
`timescale 1ns/10ps

module beat_transmit #(
	parameter int BUS_WIDTH = link_cfg_pkg::DEF_BUS_WIDTH,
	parameter int DATA_WIDTH = link_cfg_pkg::DEF_DATA_WIDTH
) (
	input wire clk,
	input wire rst_n,
	input wire in_req,
	output logic in_ack,
	input wire [DATA_WIDTH-1:0] in_data,
	output logic tx_want,
	input wire grant,
	output logic tx_valid,
	output logic [BUS_WIDTH-1:0] tx_data,
	output logic tx_last,
	input wire tx_ready
);
	import link_cfg_pkg::*;

	localparam int BEATS = DATA_WIDTH / BUS_WIDTH;
	localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS - 1);

	typedef enum logic [1:0] {
		idle,
		load,
		send,
		wait_drop
	} tx_state_t;

	tx_state_t state;
	beat_cnt_t beat_cnt;
	logic [DATA_WIDTH-1:0] shift_reg;
	logic take_word;
	logic beat_done;

	// new word only once the previous handshake has fully closed
	assign take_word = (state == idle) && in_req && !in_ack;

	assign tx_valid = (state == send);
	assign tx_data = shift_reg[BUS_WIDTH-1:0];
	assign tx_last = (state == send) && (beat_cnt == LAST_BEAT);
	assign beat_done = tx_valid && tx_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			in_ack <= 1'b0;
			tx_want <= 1'b0;
			beat_cnt <= '0;
		end else begin
			// ack follows req down, may overlap the send
			if (in_ack && !in_req) begin
				in_ack <= 1'b0;
			end
			case (state)
				idle: begin
					if (take_word) begin
						in_ack <= 1'b1;
						tx_want <= 1'b1;
						state <= load;
					end
				end
				load: begin
					beat_cnt <= '0;
					if (grant) begin
						state <= send;
					end
				end
				send: begin
					if (beat_done) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (tx_last) begin
							tx_want <= 1'b0;
							state <= wait_drop;
						end
					end
				end
				wait_drop: begin
					// ack low means req already fell, a raised req is the next word
					if (!in_ack) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// lsb beat first
	always_ff @(posedge clk) begin
		if (take_word) begin
			shift_reg <= in_data;
		end else if (beat_done) begin
			shift_reg <= shift_reg >> BUS_WIDTH;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_layout_pkg.sv
`default_nettype none

package mem_layout_pkg;

	// low 16 bits of a source 1 word
	typedef logic [15:0] addr_t;

	typedef logic [1:0] region_t;

	localparam int N_REGION = 4;

	// each region runs up to the next base, the last one to 0xFFFF
	localparam addr_t REGION_BASE [N_REGION] = '{
		16'h0000,
		16'h1000,
		16'h4000,
		16'h8000
	};

	// highest region whose base is not above addr
	function automatic region_t addr_to_region(input addr_t addr);
		region_t region;
		region = '0;
		for (int i = 0; i < N_REGION; i++) begin
			if (addr >= REGION_BASE[i]) begin
				region = region_t'(i);
			end
		end
		return region;
	endfunction

endpackage

`default_nettype wire

//--- rtl/link_cfg_pkg.sv
`default_nettype none

package link_cfg_pkg;

	// transmitters sharing the bus
	localparam int N_SRC = 2;

	// source id carried with every beat
	typedef logic [$clog2(N_SRC)-1:0] src_t;

	localparam src_t SRC_RAW = 1'b0;
	localparam src_t SRC_ADDR = 1'b1;

	// default link widths
	localparam int DEF_BUS_WIDTH = 8;
	localparam int DEF_DATA_WIDTH = 32;

	// beats per word, counted on both ends of the bus
	typedef logic [7:0] beat_cnt_t;

endpackage

`default_nettype wire
